// ==== decodeFront.f ====
+incdir+dv
hdl/cpuCtrlPkg.sv
hdl/ctrlIf.sv
hdl/controlUnit.sv
hdl/ctrlQueue.sv
hdl/branchResolver.sv
hdl/decodeFront.sv
dv/decodeTb.sv

// ==== dv/decodeModel.svh ====
//////////////////////////////////////////////////
// Reference model of decode, branch resolution
// and prediction check, included by the testbench
//////////////////////////////////////////////////

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Record layout {ctrl, wenBtb, wenBht, updatePc, target, pc}
localparam int RecTgtLsb  = DataW;
localparam int RecUpdBit  = 2 * DataW;
localparam int RecBhtBit  = RecUpdBit + 1;
localparam int RecBtbBit  = RecUpdBit + 2;
localparam int RecCtrlLsb = RecUpdBit + 3;
localparam int RecW       = RecCtrlLsb + CtrlW;

// Control bits each opcode should raise
function automatic logic [CtrlW-1:0] decodeCtrl(input logic [OpW-1:0] op);
    logic [CtrlW-1:0] c;
    c                  = '0;
    c[AluSrcBit]       = op inside {OpSll, OpSra, OpRor, OpLw, OpSw, OpLlb, OpLhb};
    c[RegSrcBit]       = op inside {OpLlb, OpLhb};
    c[ZEnBit]          = op inside {OpAdd, OpSub, OpXor, OpSll, OpSra, OpRor};
    c[NvEnBit]         = op inside {OpAdd, OpSub};
    c[MemEnableBit]    = op inside {OpLw, OpSw};
    c[MemWriteBit]     = (op == OpSw);
    c[RegWriteBit]     = !(op inside {OpSw, OpB, OpBr, OpHlt});  // Branches never write
    c[MemToRegBit]     = op inside {OpLw, OpSw};
    c[HltBit]          = (op == OpHlt);
    c[PcsBit]          = (op == OpPcs);
    c[BranchBit]       = op inside {OpB, OpBr};
    c[IsBrBit]         = (op == OpBr);
    c[AluOpLsb +: OpW] = op;                     // ALU op is the opcode
    return c;
endfunction

// Flags are Z, V, N from high to low
function automatic logic condHolds(input logic [CondW-1:0] cond, input logic [FlagW-1:0] f);
    case (cond)
        CondNe:  return !f[2];
        CondEq:  return f[2];
        CondGt:  return !f[2] && !f[0];
        CondLt:  return f[0];
        CondGe:  return f[2] || !f[0];
        CondLe:  return f[2] || f[0];
        CondOv:  return f[1];
        default: return 1'b1;                    // Unconditional
    endcase
endfunction

// Where the branch goes if taken
function automatic logic [DataW-1:0] branchTarget(input logic [DataW-1:0] word,
                                                  input logic [DataW-1:0] pc,
                                                  input logic [DataW-1:0] regTarget);
    logic [DataW-1:0] off;
    off = DataW'($signed(word[OffW-1:0]));       // Sign-extended word offset
    if (word[DataW-1 -: OpW] == OpBr) begin
        return regTarget;
    end
    return pc + DataW'(2) + DataW'(2) * off;
endfunction

// Full output record for one instruction
function automatic logic [RecW-1:0] resolveRecord(input logic [DataW-1:0] word,
    input logic [DataW-1:0] pc, input logic predTaken, input logic [DataW-1:0] predTarget,
    input logic [FlagW-1:0] flags, input logic [DataW-1:0] regTarget);
    logic [OpW-1:0]   op;
    logic             isBranch;
    logic             taken;
    logic [DataW-1:0] target;
    logic             wrongTarget;
    op          = word[DataW-1 -: OpW];
    isBranch    = op inside {OpB, OpBr};
    taken       = isBranch && condHolds(word[OffW +: CondW], flags);
    target      = branchTarget(word, pc, regTarget);
    wrongTarget = isBranch && (target != predTarget);
    return {decodeCtrl(op), wrongTarget, isBranch,
            isBranch && (wrongTarget || (predTaken != taken)),
            taken ? target : pc + DataW'(2), pc};
endfunction

`endif

// ==== dv/decodeTb.sv ====
//////////////////////////////////////////////////
// Testbench for the decode front
// Random traffic against a reference model, with
// back-pressure and full-rate phases
//////////////////////////////////////////////////

module decodeTb
    import cpuCtrlPkg::*;
();

    `include "decodeModel.svh"

    localparam int ClkPeriod   = 10;
    localparam int QueueDepth  = 4;
    localparam int RandCount   = 300;            // Mixed valid/ready traffic
    localparam int BpRounds    = 4;
    localparam int BpCount     = 20;             // Instructions per stall round
    localparam int StallCycles = 24;             // Long enough to fill everything
    localparam int FlowCount   = 200;            // Full-rate run
    localparam int QuietCycles = QueueDepth + 3; // Longer than the pipeline holds
    localparam int TotalInstr  = RandCount + BpRounds * BpCount + FlowCount;
    localparam int WatchdogTime = (TotalInstr * 20 + 50) * ClkPeriod;

    logic             clk;
    logic             arstN;
    logic             inValid;
    logic             inReady;
    instrWord_u       inInstr;
    logic [DataW-1:0] inPc;
    logic             inPredTaken;
    logic [DataW-1:0] inPredTarget;
    logic [FlagW-1:0] inFlags;
    logic [DataW-1:0] inRegTarget;
    logic             outValid;
    logic             outReady;
    logic [CtrlW-1:0] outCtrl;
    logic             outWenBtb;
    logic             outWenBht;
    logic             outUpdatePc;
    logic [DataW-1:0] outTarget;
    logic [DataW-1:0] outPc;

    logic [RecW-1:0]  expQ [$];                  // Records still to come out
    logic             inFire;                    // Input transfers at next rising edge
    int               sentCount;
    int               sendLimit;                 // No new input once reached
    int               validPct;
    int               readyPct;
    int               stallCount;
    string            testName;

    decodeFront #(
        .QueueDepth (QueueDepth)
    ) dut (
        .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady),
        .inInstr(inInstr), .inPc(inPc), .inPredTaken(inPredTaken),
        .inPredTarget(inPredTarget), .inFlags(inFlags), .inRegTarget(inRegTarget),
        .outValid(outValid), .outReady(outReady), .outCtrl(outCtrl),
        .outWenBtb(outWenBtb), .outWenBht(outWenBht), .outUpdatePc(outUpdatePc),
        .outTarget(outTarget), .outPc(outPc)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogTime);
        failRun("watchdog expired, the run hung waiting on the DUT");
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////
    task automatic failRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkEq(input string name, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (expVal !== actVal) begin
            failRun($sformatf("error %s expected %0h actual %0h", name, expVal, actVal));
        end
    endtask

    // Output record is stable here and leaves at the next rising edge
    task automatic scoreOutput();
        logic [RecW-1:0] exp;
        if (expQ.size() == 0) begin
            failRun("output record appeared with no instruction outstanding");
        end
        exp = expQ.pop_front();
        checkEq({testName, " outPc"}, 32'(exp[DataW-1:0]), 32'(outPc));   // Order first
        checkEq({testName, " outCtrl"}, 32'(exp[RecCtrlLsb +: CtrlW]), 32'(outCtrl));
        checkEq({testName, " outWenBtb"}, 32'(exp[RecBtbBit]), 32'(outWenBtb));
        checkEq({testName, " outWenBht"}, 32'(exp[RecBhtBit]), 32'(outWenBht));
        checkEq({testName, " outUpdatePc"}, 32'(exp[RecUpdBit]), 32'(outUpdatePc));
        checkEq({testName, " outTarget"}, 32'(exp[RecTgtLsb +: DataW]), 32'(outTarget));
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic newInstr();
        logic [OpW-1:0]   op;
        logic [DataW-1:0] word;
        if ($urandom_range(0, 9) < 4) begin
            op = ($urandom_range(0, 1) != 0) ? OpB : OpBr;  // Branches weighted up
        end else begin
            op = OpW'($urandom_range(0, 15));
        end
        word           = {op, 12'($urandom)};    // Condition and offset random
        inInstr.brView = word;
        inPc           = {15'($urandom), 1'b0};
        inFlags        = FlagW'($urandom);
        inRegTarget    = {15'($urandom), 1'b0};
        inPredTaken    = ($urandom_range(0, 1) != 0);
        if ($urandom_range(0, 1) != 0) begin
            inPredTarget = branchTarget(word, inPc, inRegTarget);  // Correct guess
        end else begin
            inPredTarget = DataW'($urandom);
        end
    endtask

    // Drives and samples on the falling edge
    task automatic stepCycle();
        @(negedge clk);
        if (!inValid || inFire) begin            // Hold data until it transfers
            inValid = ($urandom_range(1, 100) <= validPct) && (sentCount < sendLimit);
            if (inValid) begin
                newInstr();
            end
        end
        outReady = ($urandom_range(1, 100) <= readyPct);
        inFire   = inValid && inReady;           // inReady depends on registers only
        if (inFire) begin
            expQ.push_back(resolveRecord(inInstr.brView, inPc, inPredTaken, inPredTarget,
                                         inFlags, inRegTarget));
            sentCount++;
        end
        if (outValid && outReady) begin
            scoreOutput();
        end
    endtask

    task automatic sendInstrs(input int count);
        sendLimit = sentCount + count;
        while (sentCount < sendLimit) begin
            stepCycle();
        end
    endtask

    task automatic drainPipe();
        sendLimit = sentCount;
        readyPct  = 100;
        while (expQ.size() != 0) begin
            stepCycle();
        end
        repeat (QuietCycles) stepCycle();        // Any record now is a duplicate
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h663e_51ba));
        arstN        = 1'b0;
        inValid      = 1'b0;
        inInstr      = '0;
        inPc         = '0;
        inPredTaken  = 1'b0;
        inPredTarget = '0;
        inFlags      = '0;
        inRegTarget  = '0;
        outReady     = 1'b0;
        inFire       = 1'b0;
        sentCount    = 0;
        sendLimit    = 0;
        stallCount   = 0;
        testName     = "reset";

        repeat (8) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkEq("reset outValid", 32'd0, 32'(outValid));
        checkEq("reset inReady", 32'd1, 32'(inReady));

        testName = "random";
        validPct = 70;
        readyPct = 60;
        sendInstrs(RandCount);
        drainPipe();

        testName = "backpressure";
        for (int r = 0; r < BpRounds; r++) begin
            validPct  = 100;
            readyPct  = 0;                       // Sink stalls the whole time
            sendLimit = sentCount + BpCount;
            repeat (StallCycles) stepCycle();
            checkEq("backpressure inReady", 32'd0, 32'(inReady));
            checkEq("backpressure held entries", 32'(QueueDepth + 2), 32'(expQ.size()));
            validPct = 70;
            readyPct = 50;
            while (sentCount < sendLimit) begin
                stepCycle();
            end
            drainPipe();
        end

        testName  = "throughput";
        validPct  = 100;
        readyPct  = 100;
        sendLimit = sentCount + FlowCount;
        while (sentCount < sendLimit) begin
            stepCycle();
            if (inValid && !inReady) begin
                stallCount++;                    // Lost a cycle at full rate
            end
        end
        drainPipe();
        checkEq("throughput input stalls", 32'd0, 32'(stallCount));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== hdl/branchResolver.sv ====
//////////////////////////////////////////////////
// Branch resolution and prediction check
// Takes the queue head, registers one output
// record per instruction under outValid/outReady
//////////////////////////////////////////////////

module branchResolver
    import cpuCtrlPkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    ctrlIf.dst               resQ,
    output logic             outValid,
    input  logic             outReady,
    output logic [CtrlW-1:0] outCtrl,
    output logic             outWenBtb,
    output logic             outWenBht,
    output logic             outUpdatePc,
    output logic [DataW-1:0] outTarget,
    output logic [DataW-1:0] outPc
);

    logic [CondW-1:0] cond;                      // Condition from branch view
    logic [OffW-1:0]  offset;                    // Signed word offset
    logic [DataW-1:0] offsetExt;                 // Sign-extended, times two
    logic [DataW-1:0] pcPlus2;
    logic [DataW-1:0] actualTarget;              // Where a taken branch goes
    logic             isBranch;
    logic             condTrue;
    logic             taken;
    logic             mispredicted;              // Direction guess wrong
    logic             targetMiscomputed;         // BTB target wrong
    logic             accept;                    // Head transfer this cycle
    logic [CtrlW-1:0] ctrlNext;

    assign cond   = resQ.instr.brView[OffW +: CondW];
    assign offset = resQ.instr.brView[OffW-1:0];

    assign isBranch  = resQ.ctrl[BranchBit];
    assign pcPlus2   = resQ.pc + DataW'(2);
    assign offsetExt = {{(DataW-OffW-1){offset[OffW-1]}}, offset, 1'b0};

    //////////////////////////////////////////////////
    // Condition against Z/V/N
    //////////////////////////////////////////////////
    always_comb begin
        case (cond)
            CondNe:  condTrue = !resQ.flags[FlagZ];
            CondEq:  condTrue = resQ.flags[FlagZ];
            CondGt:  condTrue = !resQ.flags[FlagZ] && !resQ.flags[FlagN];
            CondLt:  condTrue = resQ.flags[FlagN];
            CondGe:  condTrue = resQ.flags[FlagZ] || !resQ.flags[FlagN];
            CondLe:  condTrue = resQ.flags[FlagZ] || resQ.flags[FlagN];
            CondOv:  condTrue = resQ.flags[FlagV];
            CondUn:  condTrue = 1'b1;            // Unconditional
            default: condTrue = 1'b0;
        endcase
    end

    assign taken = isBranch && condTrue;

    // BR jumps to the register, B is PC-relative
    assign actualTarget = resQ.ctrl[IsBrBit] ? resQ.regTarget : pcPlus2 + offsetExt;

    // Prediction check
    assign mispredicted      = (resQ.predTaken != taken);
    assign targetMiscomputed = (resQ.predTarget != actualTarget);

    always_comb begin
        ctrlNext = resQ.ctrl;
        if (isBranch) begin
            ctrlNext[RegWriteBit] = 1'b0;        // Branches never write back
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////
    assign resQ.ready = !outValid || outReady;
    assign accept     = resQ.valid && resQ.ready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;                    // Record taken downstream
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outCtrl     <= ctrlNext;
            outWenBtb   <= isBranch && targetMiscomputed;
            outWenBht   <= isBranch;             // Every branch trains the BHT
            outUpdatePc <= isBranch && (mispredicted || targetMiscomputed);
            outTarget   <= taken ? actualTarget : pcPlus2;
            outPc       <= resQ.pc;
        end
    end

endmodule

// ==== hdl/controlUnit.sv ====
//////////////////////////////////////////////////
// Opcode decoder with a one-entry output register
// Accepts one word per transfer, result on decQ
// one cycle later
//////////////////////////////////////////////////

module controlUnit
    import cpuCtrlPkg::*;
(
    input  logic             clk,
    input  logic             arstN,
    input  logic             inValid,
    output logic             inReady,
    input  instrWord_u       inInstr,
    input  logic [DataW-1:0] inPc,
    input  logic             inPredTaken,
    input  logic [DataW-1:0] inPredTarget,
    input  logic [FlagW-1:0] inFlags,
    input  logic [DataW-1:0] inRegTarget,
    ctrlIf.src               decQ
);

    logic [OpW-1:0]   opcode;                    // Opcode nibble
    logic [CtrlW-1:0] ctrlNext;                  // Decoded bits for this word
    logic             load;                      // Input transfer this cycle

    assign opcode  = inInstr.regView[FldOp];
    assign inReady = !decQ.valid || decQ.ready;  // Empty or draining now
    assign load    = inValid && inReady;

    //////////////////////////////////////////////////
    // Decode table
    //////////////////////////////////////////////////
    always_comb begin
        ctrlNext                     = '0;       // Defaults first
        ctrlNext[RegWriteBit]        = 1'b1;     // Most ops write a register
        ctrlNext[AluOpLsb +: OpW]    = opcode;   // ALU op follows opcode

        case (opcode)
            OpAdd, OpSub: begin
                ctrlNext[ZEnBit]  = 1'b1;
                ctrlNext[NvEnBit] = 1'b1;        // Arithmetic sets N and V too
            end
            OpXor: begin
                ctrlNext[ZEnBit] = 1'b1;
            end
            OpSll, OpSra, OpRor: begin
                ctrlNext[AluSrcBit] = 1'b1;      // Shift amount is immediate
                ctrlNext[ZEnBit]    = 1'b1;
            end
            OpRed, OpPaddsb: begin
                // Plain register write, defaults hold
            end
            OpLw: begin
                ctrlNext[AluSrcBit]    = 1'b1;   // Base plus offset
                ctrlNext[MemToRegBit]  = 1'b1;   // Writeback from memory
                ctrlNext[MemEnableBit] = 1'b1;
            end
            OpSw: begin
                ctrlNext[AluSrcBit]    = 1'b1;
                ctrlNext[RegWriteBit]  = 1'b0;   // Store writes no register
                ctrlNext[MemEnableBit] = 1'b1;
                ctrlNext[MemToRegBit]  = 1'b1;   // Don't care on a store
                ctrlNext[MemWriteBit]  = 1'b1;
            end
            OpLlb, OpLhb: begin
                ctrlNext[AluSrcBit] = 1'b1;      // Byte immediate
                ctrlNext[RegSrcBit] = 1'b1;      // Read port 1 takes rd
            end
            OpB: begin
                ctrlNext[BranchBit]   = 1'b1;
                ctrlNext[RegWriteBit] = 1'b0;
            end
            OpBr: begin
                ctrlNext[BranchBit]   = 1'b1;
                ctrlNext[IsBrBit]     = 1'b1;    // Target from register
                ctrlNext[RegWriteBit] = 1'b0;
            end
            OpPcs: begin
                ctrlNext[PcsBit] = 1'b1;         // Writes PC+2 to rd
            end
            OpHlt: begin
                ctrlNext[HltBit]      = 1'b1;
                ctrlNext[RegWriteBit] = 1'b0;
            end
            default: begin
                ctrlNext[RegWriteBit] = 1'b1;    // Unreachable with 4-bit opcode
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decQ.valid <= 1'b0;
        end else if (load) begin
            decQ.valid <= 1'b1;                  // New entry replaces or fills
        end else if (decQ.ready) begin
            decQ.valid <= 1'b0;                  // Drained with nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            decQ.instr      <= inInstr;
            decQ.ctrl       <= ctrlNext;
            decQ.pc         <= inPc;
            decQ.predTaken  <= inPredTaken;
            decQ.predTarget <= inPredTarget;
            decQ.flags      <= inFlags;
            decQ.regTarget  <= inRegTarget;
        end
    end

endmodule

// ==== hdl/cpuCtrlPkg.sv ====
//////////////////////////////////////////////////
// Shared definitions for the decode front
// Opcodes, field widths, control-bit positions,
// condition codes and the instruction-word union
//////////////////////////////////////////////////

package cpuCtrlPkg;

    localparam int DataW = 16;                   // Word and address width
    localparam int OpW   = 4;                    // Opcode width
    localparam int CondW = 3;                    // Branch condition width
    localparam int OffW  = 9;                    // Signed word offset of B
    localparam int FlagW = 3;                    // Z, V, N

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////
    localparam logic [OpW-1:0] OpAdd    = 4'h0;
    localparam logic [OpW-1:0] OpSub    = 4'h1;
    localparam logic [OpW-1:0] OpXor    = 4'h2;
    localparam logic [OpW-1:0] OpRed    = 4'h3;  // Reduction add, plain reg write
    localparam logic [OpW-1:0] OpSll    = 4'h4;
    localparam logic [OpW-1:0] OpSra    = 4'h5;
    localparam logic [OpW-1:0] OpRor    = 4'h6;
    localparam logic [OpW-1:0] OpPaddsb = 4'h7;
    localparam logic [OpW-1:0] OpLw     = 4'h8;
    localparam logic [OpW-1:0] OpSw     = 4'h9;
    localparam logic [OpW-1:0] OpLlb    = 4'hA;
    localparam logic [OpW-1:0] OpLhb    = 4'hB;
    localparam logic [OpW-1:0] OpB      = 4'hC;  // PC-relative branch
    localparam logic [OpW-1:0] OpBr     = 4'hD;  // Register branch
    localparam logic [OpW-1:0] OpPcs    = 4'hE;
    localparam logic [OpW-1:0] OpHlt    = 4'hF;

    //////////////////////////////////////////////////
    // Control-bit positions, aluOp field on top
    //////////////////////////////////////////////////
    localparam int AluSrcBit    = 0;
    localparam int RegSrcBit    = 1;
    localparam int ZEnBit       = 2;
    localparam int NvEnBit      = 3;
    localparam int MemEnableBit = 4;
    localparam int MemWriteBit  = 5;
    localparam int RegWriteBit  = 6;
    localparam int MemToRegBit  = 7;
    localparam int HltBit       = 8;
    localparam int PcsBit       = 9;
    localparam int BranchBit    = 10;
    localparam int IsBrBit      = 11;            // BR only
    localparam int AluOpLsb     = 12;
    localparam int CtrlW        = AluOpLsb + OpW;  // Total control word width

    // Branch conditions
    localparam logic [CondW-1:0] CondNe = 3'd0;
    localparam logic [CondW-1:0] CondEq = 3'd1;
    localparam logic [CondW-1:0] CondGt = 3'd2;
    localparam logic [CondW-1:0] CondLt = 3'd3;
    localparam logic [CondW-1:0] CondGe = 3'd4;
    localparam logic [CondW-1:0] CondLe = 3'd5;
    localparam logic [CondW-1:0] CondOv = 3'd6;
    localparam logic [CondW-1:0] CondUn = 3'd7;

    // Flag positions, Z on top
    localparam int FlagZ = 2;
    localparam int FlagV = 1;
    localparam int FlagN = 0;

    localparam int FldOp = 3;                    // Opcode nibble in the register view

    // Nibbles of regView from high to low: opcode, rd, rs, rt
    // brView holds opcode, condition and offset as bit slices
    typedef union packed {
        logic [3:0][OpW-1:0] regView;
        logic [DataW-1:0]    brView;
    } instrWord_u;

endpackage

// ==== hdl/ctrlIf.sv ====
//////////////////////////////////////////////////
// One decoded instruction with its side data
// Valid/ready handshake, src drives the payload
//////////////////////////////////////////////////

interface ctrlIf
    import cpuCtrlPkg::*;
();

    logic             valid;                     // Entry present
    logic             ready;                     // Sink can take it
    instrWord_u       instr;                     // Raw instruction word
    logic [CtrlW-1:0] ctrl;                      // Decoded control bits
    logic [DataW-1:0] pc;                        // PC of the instruction
    logic [DataW-1:0] predTarget;                // Predicted target from BTB
    logic [DataW-1:0] regTarget;                 // Register value for BR
    logic             predTaken;                 // Predicted direction from BHT
    logic [FlagW-1:0] flags;                     // Z, V, N at fetch

    modport src (
        output valid, instr, ctrl, pc, predTarget, regTarget, predTaken, flags,
        input  ready
    );

    modport dst (
        input  valid, instr, ctrl, pc, predTarget, regTarget, predTaken, flags,
        output ready
    );

endinterface

// ==== hdl/ctrlQueue.sv ====
//////////////////////////////////////////////////
// Circular FIFO of decoded entries
// Depth must be a power of two, 2 or more
//////////////////////////////////////////////////

module ctrlQueue
    import cpuCtrlPkg::*;
#(
    parameter int Depth = 4
) (
    input  logic clk,
    input  logic arstN,
    ctrlIf.dst   decQ,
    ctrlIf.src   resQ
);

    localparam int AddrW = $clog2(Depth);
    localparam int EntW  = 4 * DataW + CtrlW + 1 + FlagW;  // Whole payload

    logic [EntW-1:0] mem [Depth];                // Entry storage
    logic [AddrW:0]  wrPtr;                      // Top bit is the wrap flag
    logic [AddrW:0]  rdPtr;
    logic            full;
    logic            empty;
    logic            wrEn;
    logic            rdEn;

    // Same index with different wrap bit means full
    assign full  = (wrPtr[AddrW] != rdPtr[AddrW]) &&
                   (wrPtr[AddrW-1:0] == rdPtr[AddrW-1:0]);
    assign empty = (wrPtr == rdPtr);

    assign decQ.ready = !full;
    assign resQ.valid = !empty;

    assign wrEn = decQ.valid && decQ.ready;
    assign rdEn = resQ.valid && resQ.ready;

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= rdPtr + 1'b1;           // May pop and push together
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr[AddrW-1:0]] <= {decQ.instr, decQ.ctrl, decQ.pc, decQ.predTarget,
                                      decQ.regTarget, decQ.predTaken, decQ.flags};
        end
    end

    // Head entry straight from storage
    assign {resQ.instr, resQ.ctrl, resQ.pc, resQ.predTarget,
            resQ.regTarget, resQ.predTaken, resQ.flags} = mem[rdPtr[AddrW-1:0]];

endmodule

// ==== hdl/decodeFront.sv ====
//////////////////////////////////////////////////
// Decode-and-resolve front, top level
// Decoder feeds a FIFO that feeds the resolver,
// plain valid/ready ports on both sides
//////////////////////////////////////////////////

module decodeFront
    import cpuCtrlPkg::*;
#(
    parameter int QueueDepth = 4                 // FIFO entries, power of two
) (
    input  logic             clk,
    input  logic             arstN,

    // Fetch side
    input  logic             inValid,
    output logic             inReady,
    input  instrWord_u       inInstr,
    input  logic [DataW-1:0] inPc,
    input  logic             inPredTaken,
    input  logic [DataW-1:0] inPredTarget,
    input  logic [FlagW-1:0] inFlags,
    input  logic [DataW-1:0] inRegTarget,

    // Resolved record
    output logic             outValid,
    input  logic             outReady,
    output logic [CtrlW-1:0] outCtrl,
    output logic             outWenBtb,
    output logic             outWenBht,
    output logic             outUpdatePc,
    output logic [DataW-1:0] outTarget,
    output logic [DataW-1:0] outPc
);

    ctrlIf decQ ();                              // Decoder to FIFO
    ctrlIf resQ ();                              // FIFO to resolver

    controlUnit decoder (
        .clk          (clk),
        .arstN        (arstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .inInstr      (inInstr),
        .inPc         (inPc),
        .inPredTaken  (inPredTaken),
        .inPredTarget (inPredTarget),
        .inFlags      (inFlags),
        .inRegTarget  (inRegTarget),
        .decQ         (decQ.src)
    );

    ctrlQueue #(
        .Depth (QueueDepth)
    ) queue (
        .clk   (clk),
        .arstN (arstN),
        .decQ  (decQ.dst),
        .resQ  (resQ.src)
    );

    branchResolver resolver (
        .clk         (clk),
        .arstN       (arstN),
        .resQ        (resQ.dst),
        .outValid    (outValid),
        .outReady    (outReady),
        .outCtrl     (outCtrl),
        .outWenBtb   (outWenBtb),
        .outWenBht   (outWenBht),
        .outUpdatePc (outUpdatePc),
        .outTarget   (outTarget),
        .outPc       (outPc)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile the decode front testbench with Verilator and run it
# The exit status is nonzero when the build fails or a check stops the run
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f decodeFront.f --top-module decodeTb -o decodeTb \
    && ./obj_dir/decodeTb \
    || exit 1
